//--- pong_pkg.sv
package pong_pkg;

   // raster timing, 640x480 at 60 Hz
   localparam int h_visible = 640;
   localparam int h_front   = 16;
   localparam int h_sync    = 96;
   localparam int h_back    = 48;
   localparam int h_total   = h_visible + h_front + h_sync + h_back;

   localparam int v_visible = 480;
   localparam int v_front   = 10;
   localparam int v_sync    = 2;
   localparam int v_back    = 33;
   localparam int v_total   = v_visible + v_front + v_sync + v_back;

   // court geometry
   localparam int paddle_height = 40;
   localparam int paddle_width  = 6;
   localparam int paddle_l_col  = 8;
   localparam int paddle_r_col  = 624;
   localparam int ball_size     = 4;
   localparam int ball_l_turn   = 16;
   localparam int ball_r_turn   = 619;
   localparam int net_l         = 316;
   localparam int net_r         = 321;
   localparam int score_row     = 20;
   localparam int score_l_col   = 272;
   localparam int score_r_col   = 336;
   localparam int score_cell    = 10;

   localparam int tick_cycles_default = 251750;

   // 3x5 font, top row in bits 14:12, left column is the msb of a row
   localparam logic [0:9][14:0] digit_font = {
      15'b111_101_101_101_111,
      15'b010_010_010_010_010,
      15'b111_001_111_100_111,
      15'b111_001_111_001_111,
      15'b101_101_111_001_001,
      15'b111_100_111_001_111,
      15'b111_100_111_101_111,
      15'b111_001_001_001_001,
      15'b111_101_111_101_111,
      15'b111_101_111_001_111
   };

   typedef logic [9:0] coord_h_t;
   typedef logic [8:0] coord_v_t;
   typedef logic [3:0] digit_t;

   typedef enum logic [1:0] {ph_visible, ph_front, ph_sync, ph_back} raster_phase_e;
   typedef enum logic {dir_left, dir_right} ball_dir_e;

   typedef struct packed {
      coord_h_t h;
      coord_v_t v;
      logic     visible;
   } scan_pos_t;

   typedef struct packed {
      logic up;
      logic down;
   } buttons_t;

   // paddle centre rows
   typedef struct packed {
      coord_v_t left;
      coord_v_t right;
   } paddles_t;

   // ball centre, left edge plus 2 and top plus 2
   typedef struct packed {
      coord_h_t h;
      coord_v_t v;
   } ball_t;

   typedef struct packed {
      digit_t left;
      digit_t right;
   } scores_t;

endpackage

//--- video_timing.sv
`timescale 1ns/1ps

module video_timing (
   input  logic                clk,
   input  logic                rst,
   output pong_pkg::scan_pos_t scan,
   output logic                hs_raw,
   output logic                vs_raw
);

   pong_pkg::coord_h_t      h_cnt;
   logic [9:0]              v_cnt;
   pong_pkg::raster_phase_e h_phase;
   pong_pkg::raster_phase_e v_phase;
   logic                    h_wrap;

   // phase of the next count, given the current one
   function automatic pong_pkg::raster_phase_e phase_step(
      pong_pkg::raster_phase_e ph,
      int                      cnt,
      int                      vis,
      int                      fp,
      int                      sy,
      int                      tot
   );
      phase_step = ph;
      case (ph)
         pong_pkg::ph_visible: if (cnt == vis - 1) phase_step = pong_pkg::ph_front;
         pong_pkg::ph_front:   if (cnt == vis + fp - 1) phase_step = pong_pkg::ph_sync;
         pong_pkg::ph_sync:    if (cnt == vis + fp + sy - 1) phase_step = pong_pkg::ph_back;
         pong_pkg::ph_back:    if (cnt == tot - 1) phase_step = pong_pkg::ph_visible;
         default:              phase_step = pong_pkg::ph_visible;
      endcase
   endfunction

   assign h_wrap = (h_cnt == pong_pkg::h_total - 1);

   always_ff @(posedge clk) begin
      if (rst) begin
         h_cnt   <= '0;
         h_phase <= pong_pkg::ph_visible;
      end else begin
         h_cnt   <= h_wrap ? '0 : h_cnt + 1'b1;
         h_phase <= phase_step(h_phase, h_cnt, pong_pkg::h_visible, pong_pkg::h_front,
                               pong_pkg::h_sync, pong_pkg::h_total);
      end
   end

   // rows advance once per line
   always_ff @(posedge clk) begin
      if (rst) begin
         v_cnt   <= '0;
         v_phase <= pong_pkg::ph_visible;
      end else if (h_wrap) begin
         v_cnt   <= (v_cnt == pong_pkg::v_total - 1) ? '0 : v_cnt + 1'b1;
         v_phase <= phase_step(v_phase, v_cnt, pong_pkg::v_visible, pong_pkg::v_front,
                               pong_pkg::v_sync, pong_pkg::v_total);
      end
   end

   assign scan.h       = h_cnt;
   assign scan.v       = v_cnt[8:0];
   assign scan.visible = (h_phase == pong_pkg::ph_visible) &&
                         (v_phase == pong_pkg::ph_visible);
   assign hs_raw       = (h_phase == pong_pkg::ph_sync);
   assign vs_raw       = (v_phase == pong_pkg::ph_sync);

   a_h_range : assert property (@(posedge clk) disable iff (rst)
      h_cnt <= pong_pkg::h_total - 1)
      else $error("h counter out of range: %0d", h_cnt);

   // phase and counters must agree on visibility
   a_visible_match : assert property (@(posedge clk) disable iff (rst)
      scan.visible == (h_cnt < pong_pkg::h_visible && v_cnt < pong_pkg::v_visible))
      else $error("visible flag disagrees with counters");

endmodule

//--- paddle_control.sv
`timescale 1ns/1ps

module paddle_control #(
   parameter int tick_cycles = pong_pkg::tick_cycles_default
) (
   input  logic               clk,
   input  logic               rst,
   input  pong_pkg::buttons_t left_btn,
   input  pong_pkg::buttons_t right_btn,
   output logic               tick,
   output pong_pkg::paddles_t paddles
);

   logic [$clog2(tick_cycles + 1)-1:0] tick_cnt;
   pong_pkg::buttons_t                 left_prev;
   pong_pkg::buttons_t                 right_prev;

   // one row per debounced press, clamped so the paddle stays on screen
   function automatic pong_pkg::coord_v_t paddle_step(
      pong_pkg::coord_v_t centre,
      pong_pkg::buttons_t btn,
      pong_pkg::buttons_t prev
   );
      paddle_step = centre;
      if (btn.up && prev.up && centre > pong_pkg::paddle_height / 2) begin
         paddle_step = centre - 1'b1;
      end else if (btn.down && prev.down &&
                   centre < pong_pkg::v_visible - pong_pkg::paddle_height / 2 - 1) begin
         paddle_step = centre + 1'b1;
      end
   endfunction

   // game tick
   always_ff @(posedge clk) begin
      if (rst) begin
         tick_cnt <= '0;
         tick     <= 1'b0;
      end else begin
         tick <= (tick_cnt == tick_cycles - 1);
         if (tick_cnt == tick_cycles - 1) begin
            tick_cnt <= '0;
         end else begin
            tick_cnt <= tick_cnt + 1'b1;
         end
      end
   end

   // a button counts when it is seen at two ticks in a row
   always_ff @(posedge clk) begin
      if (rst) begin
         left_prev     <= '0;
         right_prev    <= '0;
         paddles.left  <= pong_pkg::coord_v_t'(pong_pkg::v_visible / 2);
         paddles.right <= pong_pkg::coord_v_t'(pong_pkg::v_visible / 2);
      end else if (tick) begin
         left_prev     <= left_btn;
         right_prev    <= right_btn;
         paddles.left  <= paddle_step(paddles.left, left_btn, left_prev);
         paddles.right <= paddle_step(paddles.right, right_btn, right_prev);
      end
   end

   a_paddle_clamp : assert property (@(posedge clk) disable iff (rst)
      paddles.left >= pong_pkg::paddle_height / 2 &&
      paddles.left <= pong_pkg::v_visible - pong_pkg::paddle_height / 2 - 1 &&
      paddles.right >= pong_pkg::paddle_height / 2 &&
      paddles.right <= pong_pkg::v_visible - pong_pkg::paddle_height / 2 - 1)
      else $error("paddle centre outside clamp");

endmodule

//--- ball_court.sv
`timescale 1ns/1ps

module ball_court (
   input  logic               clk,
   input  logic               rst,
   input  logic               tick,
   input  logic               score_reset,
   input  pong_pkg::paddles_t paddles,
   output pong_pkg::ball_t    ball,
   output pong_pkg::scores_t  scores
);

   pong_pkg::ball_dir_e dir;
   logic [3:0]          angle;
   logic [2:0]          slope_cnt;
   logic                step;
   logic                hit_left;
   logic                hit_right;

   function automatic logic near_paddle(pong_pkg::coord_v_t v, pong_pkg::coord_v_t centre);
      near_paddle = (v >= centre - pong_pkg::paddle_height / 2) &&
                    (v <= centre + pong_pkg::paddle_height / 2);
   endfunction

   function automatic pong_pkg::digit_t inc10(pong_pkg::digit_t d);
      inc10 = (d == 4'd9) ? 4'd0 : d + 1'b1;
   endfunction

   assign hit_left  = near_paddle(ball.v, paddles.left);
   assign hit_right = near_paddle(ball.v, paddles.right);

   always_ff @(posedge clk) begin
      if (rst) begin
         step      <= 1'b0;
         ball.h    <= pong_pkg::coord_h_t'(pong_pkg::ball_r_turn);
         ball.v    <= pong_pkg::coord_v_t'(pong_pkg::v_visible / 2);
         dir       <= pong_pkg::dir_left;
         angle     <= 4'd0;
         slope_cnt <= 3'd0;
         scores    <= '0;
      end else begin
         // paddles are settled one cycle after the tick
         step <= tick;
         if (step) begin
            if (dir == pong_pkg::dir_left && ball.h == pong_pkg::ball_l_turn) begin
               if (hit_left) begin
                  dir <= pong_pkg::dir_right;
               end else begin
                  // right scores and serves
                  scores.right <= inc10(scores.right);
                  ball.h       <= pong_pkg::coord_h_t'(pong_pkg::ball_r_turn);
                  ball.v       <= paddles.right;
                  angle        <= angle + 4'd3;
               end
            end else if (dir == pong_pkg::dir_right && ball.h == pong_pkg::ball_r_turn) begin
               if (hit_right) begin
                  dir <= pong_pkg::dir_left;
               end else begin
                  scores.left <= inc10(scores.left);
                  ball.h      <= pong_pkg::coord_h_t'(pong_pkg::ball_l_turn);
                  ball.v      <= paddles.left;
                  angle       <= angle + 4'd3;
               end
            end else begin
               if (dir == pong_pkg::dir_left) begin
                  ball.h <= ball.h - 1'b1;
               end else begin
                  ball.h <= ball.h + 1'b1;
               end
               // one row every angle+1 ticks, bit 3 set means down
               if (angle[2:0] != 3'd0) begin
                  if (slope_cnt == angle[2:0]) begin
                     slope_cnt <= 3'd0;
                     if (angle[3]) begin
                        if (ball.v == pong_pkg::v_visible - pong_pkg::ball_size / 2 - 1) begin
                           angle[3] <= 1'b0;
                        end else begin
                           ball.v <= ball.v + 1'b1;
                        end
                     end else begin
                        if (ball.v == pong_pkg::ball_size / 2) begin
                           angle[3] <= 1'b1;
                        end else begin
                           ball.v <= ball.v - 1'b1;
                        end
                     end
                  end else begin
                     slope_cnt <= slope_cnt + 1'b1;
                  end
               end
            end
         end
         if (score_reset) begin
            scores <= '0;
         end
      end
   end

   a_score_digit : assert property (@(posedge clk) disable iff (rst)
      scores.left <= 4'd9 && scores.right <= 4'd9)
      else $error("score out of digit range");

endmodule

//--- court_renderer.sv
`timescale 1ns/1ps

module court_renderer (
   input  logic                clk,
   input  logic                rst,
   input  pong_pkg::scan_pos_t scan,
   input  logic                hs_raw,
   input  logic                vs_raw,
   input  pong_pkg::paddles_t  paddles,
   input  pong_pkg::ball_t     ball,
   input  pong_pkg::scores_t   scores,
   output logic                red,
   output logic                grn,
   output logic                blu,
   output logic                hs,
   output logic                vs
);

   logic on_net;
   logic on_paddle_l;
   logic on_paddle_r;
   logic on_ball;
   logic on_digit_l;
   logic on_digit_r;
   logic on_court;

   function automatic logic in_paddle(
      pong_pkg::scan_pos_t s,
      int                  col0,
      pong_pkg::coord_v_t  centre
   );
      in_paddle = (s.h >= col0) && (s.h < col0 + pong_pkg::paddle_width) &&
                  (s.v >= centre - pong_pkg::paddle_height / 2) &&
                  (s.v < centre + pong_pkg::paddle_height / 2);
   endfunction

   // font lookup for a 3x5 digit whose top left corner sits at col0
   function automatic logic digit_pixel(
      pong_pkg::scan_pos_t s,
      int                  col0,
      pong_pkg::digit_t    d
   );
      int cx;
      int cy;
      digit_pixel = 1'b0;
      if (s.h >= col0 && s.h < col0 + 3 * pong_pkg::score_cell &&
          s.v >= pong_pkg::score_row &&
          s.v < pong_pkg::score_row + 5 * pong_pkg::score_cell) begin
         cx = (int'(s.h) - col0) / pong_pkg::score_cell;
         cy = (int'(s.v) - pong_pkg::score_row) / pong_pkg::score_cell;
         digit_pixel = pong_pkg::digit_font[d][14 - (cy * 3 + cx)];
      end
   endfunction

   // dashed net, 16 rows on and 16 off
   assign on_net = (scan.h >= pong_pkg::net_l) && (scan.h <= pong_pkg::net_r) &&
                   !scan.v[4];

   assign on_paddle_l = in_paddle(scan, pong_pkg::paddle_l_col, paddles.left);
   assign on_paddle_r = in_paddle(scan, pong_pkg::paddle_r_col, paddles.right);

   assign on_ball = (scan.h >= ball.h - pong_pkg::ball_size / 2) &&
                    (scan.h < ball.h + pong_pkg::ball_size / 2) &&
                    (scan.v >= ball.v - pong_pkg::ball_size / 2) &&
                    (scan.v < ball.v + pong_pkg::ball_size / 2);

   assign on_digit_l = digit_pixel(scan, pong_pkg::score_l_col, scores.left);
   assign on_digit_r = digit_pixel(scan, pong_pkg::score_r_col, scores.right);

   assign on_court = scan.visible &&
                     (on_net || on_paddle_l || on_paddle_r || on_ball ||
                      on_digit_l || on_digit_r);

   // colour and sync leave together, one cycle behind the scan
   always_ff @(posedge clk) begin
      if (rst) begin
         red <= 1'b0;
         grn <= 1'b0;
         blu <= 1'b0;
         hs  <= 1'b1;
         vs  <= 1'b1;
      end else begin
         red <= on_court;
         grn <= on_court;
         blu <= scan.visible;
         hs  <= !hs_raw;
         vs  <= !vs_raw;
      end
   end

endmodule

//--- pong_top.sv
`timescale 1ns/1ps

module pong_top #(
   parameter int tick_cycles = pong_pkg::tick_cycles_default
) (
   input  logic               clk,
   input  logic               rst,
   input  pong_pkg::buttons_t left_btn,
   input  pong_pkg::buttons_t right_btn,
   input  logic               score_reset,
   output logic               red,
   output logic               grn,
   output logic               blu,
   output logic               hs,
   output logic               vs
);

   pong_pkg::scan_pos_t scan;
   logic                hs_raw;
   logic                vs_raw;
   logic                tick;
   pong_pkg::paddles_t  paddles;
   pong_pkg::ball_t     ball;
   pong_pkg::scores_t   scores;

   video_timing i_timing (
      .clk    (clk),
      .rst    (rst),
      .scan   (scan),
      .hs_raw (hs_raw),
      .vs_raw (vs_raw)
   );

   paddle_control #(
      .tick_cycles (tick_cycles)
   ) i_paddles (
      .clk       (clk),
      .rst       (rst),
      .left_btn  (left_btn),
      .right_btn (right_btn),
      .tick      (tick),
      .paddles   (paddles)
   );

   ball_court i_ball (
      .clk         (clk),
      .rst         (rst),
      .tick        (tick),
      .score_reset (score_reset),
      .paddles     (paddles),
      .ball        (ball),
      .scores      (scores)
   );

   court_renderer i_render (
      .clk     (clk),
      .rst     (rst),
      .scan    (scan),
      .hs_raw  (hs_raw),
      .vs_raw  (vs_raw),
      .paddles (paddles),
      .ball    (ball),
      .scores  (scores),
      .red     (red),
      .grn     (grn),
      .blu     (blu),
      .hs      (hs),
      .vs      (vs)
   );

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
   output logic clk
);

   // 50 MHz
   initial begin
      clk = 1'b0;
   end

   always #10 clk = ~clk;

endmodule

//--- pong_tb.sv
`timescale 1ns/1ps

module pong_tb;

   localparam longint frame_cycles = 420000;
   localparam longint limit_cycles = 3360000;

   logic               clk;
   logic               rst;
   logic               score_reset;
   pong_pkg::buttons_t left_btn;
   pong_pkg::buttons_t right_btn;
   logic               red;
   logic               grn;
   logic               blu;
   logic               hs;
   logic               vs;

   longint cyc;
   int     errors;
   int     checks;
   logic   red_map [0:479][0:639];
   logic   blu_map [0:479][0:639];
   int     hs_bad;
   int     vs_bad;
   int     blank_bad;
   int     grn_bad;
   int     hs_low;
   int     vs_low;
   int     hs_falls;
   longint serve_fs;
   int     serve_row;

   tb_clock i_clock (.clk(clk));

   pong_top #(.tick_cycles(4)) i_dut (
      .clk         (clk),
      .rst         (rst),
      .left_btn    (left_btn),
      .right_btn   (right_btn),
      .score_reset (score_reset),
      .red         (red),
      .grn         (grn),
      .blu         (blu),
      .hs          (hs),
      .vs          (vs)
   );

   // edges since reset release, also the raster index of the scan
   always @(posedge clk) begin
      if (rst) begin
         cyc <= 0;
      end else begin
         cyc <= cyc + 1;
      end
   end

   function automatic logic [14:0] glyph(int d);
      case (d)
         0: glyph = 15'b111_101_101_101_111;
         1: glyph = 15'b010_010_010_010_010;
         2: glyph = 15'b111_001_111_100_111;
         3: glyph = 15'b111_001_111_001_111;
         4: glyph = 15'b101_101_111_001_001;
         5: glyph = 15'b111_100_111_001_111;
         6: glyph = 15'b111_100_111_101_111;
         7: glyph = 15'b111_001_001_001_001;
         8: glyph = 15'b111_101_111_101_111;
         default: glyph = 15'b111_101_111_001_111;
      endcase
   endfunction

   function automatic logic digit_on(int h, int v, int col0, int d);
      logic [14:0] g;
      g = glyph(d);
      digit_on = 1'b0;
      if (h >= col0 && h < col0 + 30 && v >= 20 && v < 70) begin
         digit_on = g[14 - (((v - 20) / 10) * 3 + (h - col0) / 10)];
      end
   endfunction

   // court objects without the ball
   function automatic logic court_pixel(int h, int v, int pl, int pr, int dl, int dr);
      logic net;
      logic pad;
      net = (h >= 316) && (h <= 321) && ((v & 16) == 0);
      pad = (h >= 8 && h < 14 && v >= pl - 20 && v < pl + 20) ||
            (h >= 624 && h < 630 && v >= pr - 20 && v < pr + 20);
      court_pixel = net || pad || digit_on(h, v, 272, dl) || digit_on(h, v, 336, dr);
   endfunction

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("FAILED %s expected %0d actual %0d", name, expected, actual);
      end
   endtask

   // one frame from the vs fall, which shows row 490 column 0
   task automatic capture_frame();
      int   h;
      int   v;
      logic hs_prev;
      hs_bad    = 0;
      vs_bad    = 0;
      blank_bad = 0;
      grn_bad   = 0;
      hs_low    = 0;
      vs_low    = 0;
      hs_falls  = 0;
      @(negedge vs);
      h       = 0;
      v       = 490;
      hs_prev = 1'b1;
      for (int i = 0; i < frame_cycles; i++) begin
         @(negedge clk);
         if (h < 640 && v < 480) begin
            red_map[v][h] = red;
            blu_map[v][h] = blu;
            if (grn !== red) grn_bad++;
         end else if (red || grn || blu) begin
            blank_bad++;
         end
         if (hs !== !(h >= 656 && h <= 751)) hs_bad++;
         if (vs !== !(v >= 490 && v <= 491)) vs_bad++;
         if (!hs) hs_low++;
         if (!vs) vs_low++;
         if (hs_prev && !hs) hs_falls++;
         hs_prev = hs;
         h++;
         if (h == 800) begin
            h = 0;
            v = (v == 524) ? 0 : v + 1;
         end
      end
   endtask

   task automatic check_picture(input string name, input int h0, input int h1, input int v0,
                                input int v1, input int pl, input int pr);
      logic exp;
      bit   done;
      done = 0;
      for (int v = v0; v <= v1 && !done; v++) begin
         for (int h = h0; h <= h1 && !done; h++) begin
            exp = court_pixel(h, v, pl, pr, 0, 0);
            if (red_map[v][h] !== exp) begin
               check_value($sformatf("%s red at col %0d row %0d", name, h, v),
                           exp, red_map[v][h]);
               done = 1;
            end
         end
      end
      if (!done) checks++;
   endtask

   task automatic sample_red(input longint target, output logic value);
      while (cyc < target) @(negedge clk);
      value = red;
   endtask

   // one scan line through both digits, taken straight from the raster index
   task automatic check_digit_row(input string name, input longint fs, input int row,
                                  input int dl, input int dr);
      logic got;
      logic exp;
      bit   done;
      done = 0;
      for (int c = 272; c <= 365; c++) begin
         sample_red(fs + row * 800 + c + 1, got);
         exp = court_pixel(c, row, 240, 240, dl, dr);
         if (!done && got !== exp) begin
            check_value($sformatf("%s red at col %0d row %0d", name, c, row), exp, got);
            done = 1;
         end
      end
      if (!done) checks++;
   endtask

   task automatic sync_timing();
      capture_frame();
      check_value("sync_timing hs mismatches", 0, hs_bad);
      check_value("sync_timing vs mismatches", 0, vs_bad);
      check_value("sync_timing blanking colour", 0, blank_bad);
      check_value("sync_timing hs low cycles", 96 * 525, hs_low);
      check_value("sync_timing hs falls", 525, hs_falls);
      check_value("sync_timing vs low cycles", 1600, vs_low);
      // the next frame starts right after the captured one
      @(negedge clk);
      check_value("sync_timing vs period", 0, vs);
   endtask

   task automatic reset_picture();
      // flat ball rallies on rows 238..241
      check_picture("reset_picture net", 316, 321, 0, 235, 240, 240);
      check_picture("reset_picture net", 316, 321, 246, 479, 240, 240);
      check_picture("reset_picture left paddle", 8, 13, 180, 299, 240, 240);
      check_picture("reset_picture right paddle", 624, 629, 180, 299, 240, 240);
      check_picture("reset_picture left digit", 272, 301, 20, 69, 240, 240);
      check_picture("reset_picture right digit", 336, 365, 20, 69, 240, 240);
      check_value("reset_picture background red", 0, red_map[400][100]);
      check_value("reset_picture background blu", 1, blu_map[400][100]);
      check_value("reset_picture green mismatches", 0, grn_bad);
   endtask

   task automatic paddle_move();
      // 10 ticks seen high, 9 debounced moves
      @(posedge clk);
      #2 right_btn.down = 1'b1;
      repeat (40) @(posedge clk);
      #2 right_btn.down = 1'b0;
      capture_frame();
      check_picture("paddle_move right paddle", 624, 629, 180, 299, 240, 249);
      check_picture("paddle_move left paddle", 8, 13, 180, 299, 240, 249);
   endtask

   task automatic score_and_serve();
      longint m;
      longint base;
      int     k;
      // left checks happen on ball step 604 + 1208k, at edge 2 + 4 * step
      k = 0;
      m = 2418;
      while (m < cyc + 2000 || (m % frame_cycles) < 16000 || (m % frame_cycles) > 54000) begin
         k++;
         m = 2418 + 4832 * k;
      end
      while (cyc < m - 1200) @(negedge clk);
      // 250 ticks up clamps the paddle at row 20, far above the ball row
      @(posedge clk);
      #2 left_btn.up = 1'b1;
      repeat (1000) @(posedge clk);
      #2 left_btn.up = 1'b0;
      base      = m % frame_cycles;
      serve_fs  = m - base;
      serve_row = (base - 272 + 799) / 800;
      check_digit_row("score_and_serve", serve_fs, serve_row, 0, 1);
   endtask

   task automatic score_clear();
      // next line, before the served ball can reach the left side again
      while (cyc < serve_fs + serve_row * 800 + 400) @(negedge clk);
      @(posedge clk);
      #2 score_reset = 1'b1;
      @(posedge clk);
      #2 score_reset = 1'b0;
      check_digit_row("score_reset", serve_fs, serve_row + 1, 0, 0);
   endtask

   initial begin
      repeat (limit_cycles) @(posedge clk);
      $display("timeout after %0d cycles, the tests did not finish", limit_cycles);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      errors      = 0;
      checks      = 0;
      rst         = 1'b1;
      score_reset = 1'b0;
      left_btn    = '0;
      right_btn   = '0;
      repeat (2) @(posedge clk);
      #2 rst = 1'b0;
      sync_timing();
      reset_picture();
      paddle_move();
      score_and_serve();
      score_clear();
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- list.f
pong_pkg.sv
video_timing.sv
paddle_control.sv
ball_court.sv
court_renderer.sv
pong_top.sv
tb_clock.sv
pong_tb.sv
